// File: bench/alu_ref.svh
// Reference model of the ALU for the testbench. Computes the expected
// response word of one request straight from the opcode rules: integer
// results, branch bits and the per-lane turbo results. Included inside
// the testbench module.

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// one 8-bit turbo lane, all arithmetic modulo 256
function automatic logic [7:0] calc_lane(alu_pkg::alu_op_e op, logic [7:0] a,
                                         logic [7:0] b, logic [7:0] imm);
    logic [7:0] sum;
    logic [7:0] diff;
    logic [7:0] sat;
    logic [7:0] alt;
    logic [7:0] m;
    logic [7:0] c;
    sum  = a + b;
    diff = a - b;
    if ($signed(a) > 63)
        sat = 8'd63;
    else if ($signed(a) < -63)
        sat = 8'(-63);
    else
        sat = a;
    alt = imm - b;
    // magnitude scaled by 3/4
    m = a[7] ? -a : a;
    c = m - (m >> 2);
    case (op)
        alu_pkg::TB_MAX:     return ($signed(a) >= $signed(b)) ? a : b;
        alu_pkg::TB_SCALE:   return a[7] ? -c : c;
        alu_pkg::TB_ADDS:    return sum;
        alu_pkg::TB_SUBS:    return diff;
        alu_pkg::TB_DIV_ADD: return sum >> 1;
        alu_pkg::TB_DIV_SUB: return diff >> 1;
        alu_pkg::TB_SAT_63:  return sat;
        alu_pkg::TB_SB_SAT:  return sat - b;
        alu_pkg::TB_MAXPM:   return ($signed(sum) >= $signed(alt)) ? sum : alt;
        alu_pkg::TB_ACCUPP:  return sum + imm;
        alu_pkg::TB_ACCUPM:  return sum - imm;
        alu_pkg::TB_BLEND:   return (a & imm) | (b & ~imm);
        default:             return 8'h00;
    endcase
endfunction

// expected response word for a whole request
function automatic alu_pkg::alu_resp_t alu_ref(alu_pkg::alu_req_t req);
    alu_pkg::alu_resp_t resp;
    logic [63:0] a;
    logic [63:0] b;
    logic [5:0]  sh;
    a  = req.operand_a;
    b  = req.operand_b;
    sh = b[5:0];
    resp.result = '0;
    resp.branch = 1'b1;
    case (req.op)
        alu_pkg::ADD:  resp.result = a + b;
        alu_pkg::SUB:  resp.result = a - b;
        alu_pkg::ANDL: resp.result = a & b;
        alu_pkg::ORL:  resp.result = a | b;
        alu_pkg::XORL: resp.result = a ^ b;
        alu_pkg::ANDN: resp.result = a & ~b;
        alu_pkg::ORN:  resp.result = a | ~b;
        alu_pkg::XNOR: resp.result = a ^ ~b;
        alu_pkg::SLL:  resp.result = a << sh;
        alu_pkg::SRL:  resp.result = a >> sh;
        alu_pkg::SRA:  resp.result = $signed(a) >>> sh;
        alu_pkg::SLTS: resp.result = {63'd0, $signed(a) < $signed(b)};
        alu_pkg::SLTU: resp.result = {63'd0, a < b};
        // branches leave the result at zero
        alu_pkg::EQ:   resp.branch = (a == b);
        alu_pkg::NE:   resp.branch = (a != b);
        alu_pkg::LTS:  resp.branch = $signed(a) < $signed(b);
        alu_pkg::LTU:  resp.branch = a < b;
        alu_pkg::GES:  resp.branch = $signed(a) >= $signed(b);
        alu_pkg::GEU:  resp.branch = a >= b;
        default: begin
            for (int k = 0; k < 8; k++) begin
                resp.result[8*k +: 8] = calc_lane(req.op, a[8*k +: 8], b[8*k +: 8],
                                                  req.imm[8*k +: 8]);
            end
        end
    endcase
    return resp;
endfunction

`endif

// File: bench/tb_alu.sv
// Testbench for the ALU top level. Drives requests on the falling edge,
// keeps the expected responses in a queue and compares every response
// at the next falling edge against the reference model, including the
// one-cycle latency. Stops at the first mismatch.

`timescale 1ns/10ps

module tb_alu;

    `include "alu_ref.svh"

    logic               clk_i;
    logic               rst_i;
    logic               valid_i;
    alu_pkg::alu_req_t  req_i;
    logic               valid_o;
    alu_pkg::alu_resp_t resp_o;

    // scoreboard, one entry per request in flight
    alu_pkg::alu_resp_t exp_q[$];
    string              name_q[$];
    int                 issue_q[$];
    int                 cycle_cnt = 0;

    // response resp_o must keep while valid_o is low
    alu_pkg::alu_resp_t last_resp = '0;

    logic [7:0] edge_lane [0:4] = '{8'h80, 8'h7f, 8'h3f, 8'hc1, 8'h00};

    alu_top alu_top_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic abort_run(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare_value(string name, logic [64:0] expected, logic [64:0] actual);
        if (expected !== actual)
            abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // lanes taken from the edge list, rotated by rot
    function automatic logic [63:0] edge_word(int rot);
        logic [63:0] w;
        for (int i = 0; i < 8; i++)
            w[8*i +: 8] = edge_lane[(i + rot) % 5];
        return w;
    endfunction

    task automatic send(string name, alu_pkg::alu_op_e op, logic [63:0] a,
                        logic [63:0] b, logic [63:0] imm);
        alu_pkg::alu_req_t req;
        req.op        = op;
        req.operand_a = a;
        req.operand_b = b;
        req.imm       = imm;
        @(negedge clk_i);
        valid_i = 1'b1;
        req_i   = req;
        exp_q.push_back(alu_ref(req));
        name_q.push_back($sformatf("%s %s", name, op.name()));
        issue_q.push_back(cycle_cnt);
    endtask

    task automatic go_idle(int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            valid_i = 1'b0;
        end
    endtask

    task automatic wait_drained(int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_cycles) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0)
            abort_run("expected responses did not arrive before the timeout");
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (valid_o) begin
                if (exp_q.size() == 0)
                    abort_run("valid_o went high with no request outstanding");
                compare_value({name_q[0], " latency"}, issue_q[0] + 1, cycle_cnt);
                compare_value(name_q[0], exp_q[0], resp_o);
                last_resp = resp_o;
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                void'(issue_q.pop_front());
            end else begin
                compare_value("hold resp_o", last_resp, resp_o);
                if (exp_q.size() != 0 && issue_q[0] + 1 == cycle_cnt)
                    abort_run($sformatf("response for %s did not arrive", name_q[0]));
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        logic [63:0] a;
        logic [63:0] neg;
        void'($urandom(32'h1b57e66d));
        rst_i   = 1'b1;
        valid_i = 1'b0;
        req_i   = '0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        compare_value("reset valid_o", 65'd0, {64'd0, valid_o});
        compare_value("reset resp_o", 65'd0, resp_o);
        send("first", alu_pkg::ADD, rand_word(), rand_word(), 64'd0);
        go_idle(1);
        wait_drained(10);

        // integer arithmetic and logic
        for (int k = int'(alu_pkg::ADD); k <= int'(alu_pkg::XNOR); k++)
            repeat (6) send("arith", alu_pkg::alu_op_e'(k), rand_word(), rand_word(), 64'd0);

        // shifts with edge amounts and negative operands
        for (int k = int'(alu_pkg::SLL); k <= int'(alu_pkg::SRA); k++) begin
            a = rand_word() | (64'd1 << 63);
            send("shift", alu_pkg::alu_op_e'(k), rand_word(), rand_word(), 64'd0);
            send("shift", alu_pkg::alu_op_e'(k), a, 64'd0, 64'd0);
            send("shift", alu_pkg::alu_op_e'(k), a, 64'd63, 64'd0);
            send("shift", alu_pkg::alu_op_e'(k), a, rand_word(), 64'd0);
        end
        for (int k = int'(alu_pkg::SLTS); k <= int'(alu_pkg::SLTU); k++) begin
            a   = rand_word() & ~(64'd1 << 63);
            neg = rand_word() | (64'd1 << 63);
            send("slt", alu_pkg::alu_op_e'(k), a, neg, 64'd0);
            send("slt", alu_pkg::alu_op_e'(k), neg, a, 64'd0);
            send("slt", alu_pkg::alu_op_e'(k), a, a, 64'd0);
        end

        // branch pairs: equal, signed greater, unsigned greater
        for (int k = int'(alu_pkg::EQ); k <= int'(alu_pkg::GEU); k++) begin
            a = rand_word();
            send("branch", alu_pkg::alu_op_e'(k), a, a, 64'd0);
            send("branch", alu_pkg::alu_op_e'(k), 64'd5, -64'd3, 64'd0);
            send("branch", alu_pkg::alu_op_e'(k), -64'd1, 64'd1, 64'd0);
            send("branch", alu_pkg::alu_op_e'(k), rand_word(), rand_word(), 64'd0);
        end

        // turbo lanes, edge lanes first
        for (int k = int'(alu_pkg::TB_MAX); k <= int'(alu_pkg::TB_BLEND); k++) begin
            for (int r = 0; r < 5; r++)
                send("turbo edge", alu_pkg::alu_op_e'(k), edge_word(r), edge_word(r + 1),
                     edge_word(r + 3));
            repeat (4)
                send("turbo", alu_pkg::alu_op_e'(k), rand_word(), rand_word(), rand_word());
        end
        go_idle(1);
        wait_drained(20);

        // random stream with idle gaps
        for (int n = 0; n < 200; n++) begin
            send("stream", alu_pkg::alu_op_e'($urandom_range(int'(alu_pkg::TB_BLEND), 0)),
                 rand_word(), rand_word(), rand_word());
            if ($urandom_range(3, 0) == 0)
                go_idle(1);
        end
        go_idle(1);
        wait_drained(20);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: common/alu_pkg.sv
// Shared definitions for the 64-bit integer ALU with the packed-SIMD
// turbo extension. Holds the datapath widths, the opcode list and the
// request and response words that travel between the execution stage
// and the ALU. Every other file refers to these by scoped names.

package alu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned XLEN    = 64;
    localparam int unsigned LANE_W  = 8;
    localparam int unsigned LANES   = XLEN / LANE_W;
    localparam int unsigned SHAMT_W = 6;

    // ------------------------------
    // opcodes
    // ------------------------------
    typedef enum logic [5:0] {
        // adder
        ADD, SUB,
        // logic, plain and with inverted operand b
        ANDL, ORL, XORL,
        ANDN, ORN, XNOR,
        // 64-bit shifts
        SLL, SRL, SRA,
        // set less than
        SLTS, SLTU,
        // branch compares
        EQ, NE, LTS, LTU, GES, GEU,
        // turbo lane operations on eight 8-bit lanes
        TB_MAX, TB_SCALE, TB_ADDS, TB_SUBS,
        TB_DIV_ADD, TB_DIV_SUB,
        TB_SAT_63, TB_SB_SAT,
        TB_MAXPM, TB_ACCUPP, TB_ACCUPM,
        TB_BLEND
    } alu_op_e;

    // ------------------------------
    // request and response words
    // ------------------------------
    typedef struct packed {
        alu_op_e           op;
        logic [XLEN-1:0]   operand_a;
        logic [XLEN-1:0]   operand_b;
        // third lane operand, only read by turbo ops
        logic [XLEN-1:0]   imm;
    } alu_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        // 1 for every non-branch op
        logic              branch;
    } alu_resp_t;

endpackage

// File: hdl/alu_top.sv
// Top level of the ALU. Feeds each request to the integer and the turbo
// datapath in parallel, picks the result by opcode group and registers
// it together with the branch bit. One request per cycle may be issued
// on valid_i; the response follows one cycle later on valid_o.

`timescale 1ns/10ps

module alu_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               valid_i,
    input  alu_pkg::alu_req_t  req_i,
    output logic               valid_o,
    output alu_pkg::alu_resp_t resp_o
);

    logic [alu_pkg::XLEN-1:0] int_result;
    logic [alu_pkg::XLEN-1:0] turbo_result;
    logic [alu_pkg::XLEN-1:0] result_sel;
    logic                     branch;
    logic                     is_turbo;

    int_alu_core int_alu_core_i (
        .req_i    (req_i),
        .result_o (int_result),
        .branch_o (branch)
    );

    turbo_simd turbo_simd_i (
        .req_i    (req_i),
        .result_o (turbo_result)
    );

    // turbo group decode
    assign is_turbo = req_i.op inside {
        alu_pkg::TB_MAX, alu_pkg::TB_SCALE, alu_pkg::TB_ADDS, alu_pkg::TB_SUBS,
        alu_pkg::TB_DIV_ADD, alu_pkg::TB_DIV_SUB, alu_pkg::TB_SAT_63,
        alu_pkg::TB_SB_SAT, alu_pkg::TB_MAXPM, alu_pkg::TB_ACCUPP,
        alu_pkg::TB_ACCUPM, alu_pkg::TB_BLEND
    };

    assign result_sel = is_turbo ? turbo_result : int_result;

    // ------------------------------
    // output stage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            resp_o  <= '0;
        end else begin
            valid_o <= valid_i;
            // hold the last response between requests
            if (valid_i) begin
                resp_o.result <= result_sel;
                resp_o.branch <= branch;
            end
        end
    end

endmodule

// File: int_alu/int_adder_cmp.sv
// Shared 64-bit adder of the integer datapath with the less-than compare
// and branch resolution. Operand b is inverted for subtraction and the
// inverted logic ops; the carry-in comes from a one appended to a.
// Purely combinational.

`timescale 1ns/10ps

module int_adder_cmp (
    input  alu_pkg::alu_req_t         req_i,
    output logic [alu_pkg::XLEN-1:0]  sum_o,
    output logic [alu_pkg::XLEN-1:0]  b_eff_o,
    output logic                      less_o,
    output logic                      branch_o
);

    logic                   negate_b;
    logic                   signed_cmp;
    logic                   sum_zero;
    logic [alu_pkg::XLEN:0] adder_in_a;
    logic [alu_pkg::XLEN:0] adder_in_b;
    logic [alu_pkg::XLEN:0] adder_out;

    always_comb begin
        negate_b = 1'b0;
        case (req_i.op)
            alu_pkg::SUB, alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR,
            alu_pkg::EQ, alu_pkg::NE: negate_b = 1'b1;
            default: negate_b = 1'b0;
        endcase
    end

    // lsb pair 1 + 1 gives the +1 of two's complement when b is inverted
    assign adder_in_a = {req_i.operand_a, 1'b1};
    assign adder_in_b = {req_i.operand_b, 1'b0} ^ {(alu_pkg::XLEN+1){negate_b}};
    assign adder_out  = adder_in_a + adder_in_b;

    assign sum_o    = adder_out[alu_pkg::XLEN:1];
    assign b_eff_o  = adder_in_b[alu_pkg::XLEN:1];
    assign sum_zero = ~|sum_o;

    // ------------------------------
    // compare
    // ------------------------------
    assign signed_cmp = (req_i.op == alu_pkg::SLTS) || (req_i.op == alu_pkg::LTS) ||
                        (req_i.op == alu_pkg::GES);

    // extra top bit turns the unsigned case into a signed compare
    assign less_o = $signed({signed_cmp & req_i.operand_a[alu_pkg::XLEN-1], req_i.operand_a}) <
                    $signed({signed_cmp & req_i.operand_b[alu_pkg::XLEN-1], req_i.operand_b});

    always_comb begin
        case (req_i.op)
            alu_pkg::EQ:               branch_o = sum_zero;
            alu_pkg::NE:               branch_o = ~sum_zero;
            alu_pkg::LTS, alu_pkg::LTU: branch_o = less_o;
            alu_pkg::GES, alu_pkg::GEU: branch_o = ~less_o;
            default:                   branch_o = 1'b1;
        endcase
    end

endmodule

// File: int_alu/int_alu_core.sv
// Integer datapath of the ALU. Combines the shared adder/compare block
// and the shifter with the bitwise logic and picks the result by
// opcode. Branch opcodes and turbo opcodes give a zero result here.
// Purely combinational.

`timescale 1ns/10ps

module int_alu_core (
    input  alu_pkg::alu_req_t         req_i,
    output logic [alu_pkg::XLEN-1:0]  result_o,
    output logic                      branch_o
);

    logic [alu_pkg::XLEN-1:0] sum;
    logic [alu_pkg::XLEN-1:0] b_eff;
    logic [alu_pkg::XLEN-1:0] shift_result;
    logic                     less;

    int_adder_cmp int_adder_cmp_i (
        .req_i    (req_i),
        .sum_o    (sum),
        .b_eff_o  (b_eff),
        .less_o   (less),
        .branch_o (branch_o)
    );

    // shift amount from the low bits of operand b
    int_shifter int_shifter_i (
        .op_i      (req_i.op),
        .operand_i (req_i.operand_a),
        .shamt_i   (req_i.operand_b[alu_pkg::SHAMT_W-1:0]),
        .result_o  (shift_result)
    );

    // ------------------------------
    // result select
    // ------------------------------
    always_comb begin
        result_o = '0;
        case (req_i.op)
            alu_pkg::ADD, alu_pkg::SUB:   result_o = sum;
            // b_eff is already inverted for the N forms
            alu_pkg::ANDL, alu_pkg::ANDN: result_o = req_i.operand_a & b_eff;
            alu_pkg::ORL, alu_pkg::ORN:   result_o = req_i.operand_a | b_eff;
            alu_pkg::XORL, alu_pkg::XNOR: result_o = req_i.operand_a ^ b_eff;
            alu_pkg::SLL, alu_pkg::SRL,
            alu_pkg::SRA:                 result_o = shift_result;
            alu_pkg::SLTS, alu_pkg::SLTU: result_o = {{(alu_pkg::XLEN-1){1'b0}}, less};
            default:                      result_o = '0;
        endcase
    end

endmodule

// File: int_alu/int_shifter.sv
// 64-bit shifter for SLL, SRL and SRA. Only a right shifter is built;
// left shifts reverse the operand bits on the way in and the result
// bits on the way out. Purely combinational.

`timescale 1ns/10ps

module int_shifter (
    input  alu_pkg::alu_op_e             op_i,
    input  logic [alu_pkg::XLEN-1:0]     operand_i,
    input  logic [alu_pkg::SHAMT_W-1:0]  shamt_i,
    output logic [alu_pkg::XLEN-1:0]     result_o
);

    logic                   shift_left;
    logic                   shift_arith;
    logic [alu_pkg::XLEN-1:0] operand_rev;
    logic [alu_pkg::XLEN-1:0] shift_in;
    logic [alu_pkg::XLEN:0]   shift_in_ext;
    logic [alu_pkg::XLEN:0]   right_ext;
    logic [alu_pkg::XLEN-1:0] right_rev;

    assign shift_left  = (op_i == alu_pkg::SLL);
    assign shift_arith = (op_i == alu_pkg::SRA);

    // bit reversal in both directions
    always_comb begin
        for (int k = 0; k < alu_pkg::XLEN; k++) begin
            operand_rev[k] = operand_i[alu_pkg::XLEN-1-k];
            right_rev[k]   = right_ext[alu_pkg::XLEN-1-k];
        end
    end

    assign shift_in = shift_left ? operand_rev : operand_i;

    // sign fill only for SRA, zero otherwise
    assign shift_in_ext = {shift_arith & shift_in[alu_pkg::XLEN-1], shift_in};
    assign right_ext    = $unsigned($signed(shift_in_ext) >>> shamt_i);

    assign result_o = shift_left ? right_rev : right_ext[alu_pkg::XLEN-1:0];

endmodule

// File: sim.f
common/alu_pkg.sv
int_alu/int_adder_cmp.sv
int_alu/int_shifter.sv
int_alu/int_alu_core.sv
turbo/turbo_lane.sv
turbo/turbo_simd.sv
hdl/alu_top.sv
+incdir+bench
bench/tb_alu.sv

// File: turbo/turbo_lane.sv
// One 8-bit lane of the turbo extension. Computes every kept lane
// operation on a, b and imm and selects one by opcode. All arithmetic
// wraps modulo 256; comparisons treat lanes as signed.
// Non-turbo opcodes give zero. Purely combinational.

`timescale 1ns/10ps

module turbo_lane (
    input  alu_pkg::alu_op_e            op_i,
    input  logic [alu_pkg::LANE_W-1:0]  a_i,
    input  logic [alu_pkg::LANE_W-1:0]  b_i,
    input  logic [alu_pkg::LANE_W-1:0]  imm_i,
    output logic [alu_pkg::LANE_W-1:0]  result_o
);

    // clamp bounds of SAT_63, +63 and -63
    localparam logic [alu_pkg::LANE_W-1:0] SAT_HI = 8'h3f;
    localparam logic [alu_pkg::LANE_W-1:0] SAT_LO = 8'hc1;

    logic [alu_pkg::LANE_W-1:0] r_max;
    logic [alu_pkg::LANE_W-1:0] r_add;
    logic [alu_pkg::LANE_W-1:0] r_sub;
    logic [alu_pkg::LANE_W-1:0] r_sat63;
    logic [alu_pkg::LANE_W-1:0] r_sb_sat;
    logic [alu_pkg::LANE_W-1:0] r_imm_sub;
    logic [alu_pkg::LANE_W-1:0] r_maxpm;
    logic [alu_pkg::LANE_W-1:0] r_blend;
    logic [alu_pkg::LANE_W-1:0] mag;
    logic [alu_pkg::LANE_W-1:0] scaled;
    logic [alu_pkg::LANE_W-1:0] r_scale;

    assign r_max = ($signed(a_i) <= $signed(b_i)) ? b_i : a_i;
    assign r_add = a_i + b_i;
    assign r_sub = a_i - b_i;

    // saturate a to -63..63
    assign r_sat63 = ($signed(a_i) > $signed(SAT_HI)) ? SAT_HI :
                     ($signed(a_i) < $signed(SAT_LO)) ? SAT_LO : a_i;
    assign r_sb_sat = r_sat63 - b_i;

    // larger of a+b and imm-b
    assign r_imm_sub = imm_i - b_i;
    assign r_maxpm   = ($signed(r_add) < $signed(r_imm_sub)) ? r_imm_sub : r_add;

    assign r_blend = (a_i & imm_i) | (b_i & ~imm_i);

    // scale by 3/4 on the magnitude, sign restored afterwards
    assign mag     = a_i[alu_pkg::LANE_W-1] ? -a_i : a_i;
    assign scaled  = mag - (mag >> 2);
    assign r_scale = a_i[alu_pkg::LANE_W-1] ? -scaled : scaled;

    // ------------------------------
    // lane result select
    // ------------------------------
    always_comb begin
        case (op_i)
            alu_pkg::TB_MAX:     result_o = r_max;
            alu_pkg::TB_SCALE:   result_o = r_scale;
            alu_pkg::TB_ADDS:    result_o = r_add;
            alu_pkg::TB_SUBS:    result_o = r_sub;
            alu_pkg::TB_DIV_ADD: result_o = r_add >> 1;
            alu_pkg::TB_DIV_SUB: result_o = r_sub >> 1;
            alu_pkg::TB_SAT_63:  result_o = r_sat63;
            alu_pkg::TB_SB_SAT:  result_o = r_sb_sat;
            alu_pkg::TB_MAXPM:   result_o = r_maxpm;
            alu_pkg::TB_ACCUPP:  result_o = r_add + imm_i;
            alu_pkg::TB_ACCUPM:  result_o = r_add - imm_i;
            alu_pkg::TB_BLEND:   result_o = r_blend;
            default:             result_o = '0;
        endcase
    end

endmodule

// File: turbo/turbo_simd.sv
// Packed-SIMD turbo datapath. Cuts operand a, operand b and imm into
// eight 8-bit lanes, lane i on bits 8i..8i+7, runs one turbo_lane per
// lane and packs the lane results back into a 64-bit word.
// Purely combinational.

`timescale 1ns/10ps

module turbo_simd (
    input  alu_pkg::alu_req_t         req_i,
    output logic [alu_pkg::XLEN-1:0]  result_o
);

    // ------------------------------
    // lane array
    // ------------------------------
    for (genvar i = 0; i < alu_pkg::LANES; i++) begin : gen_lane
        turbo_lane turbo_lane_i (
            .op_i     (req_i.op),
            .a_i      (req_i.operand_a[i*alu_pkg::LANE_W +: alu_pkg::LANE_W]),
            .b_i      (req_i.operand_b[i*alu_pkg::LANE_W +: alu_pkg::LANE_W]),
            .imm_i    (req_i.imm[i*alu_pkg::LANE_W +: alu_pkg::LANE_W]),
            .result_o (result_o[i*alu_pkg::LANE_W +: alu_pkg::LANE_W])
        );
    end

endmodule
